/* list.f */
+incdir+rtl
rtl/fAddPkg.sv
rtl/fAddAlign.sv
rtl/fAddSum.sv
rtl/fAddPack.sv
rtl/ringBuffCtrl.sv
rtl/fAddUnit.sv
testbench/fAddUnit_asserts.sv
testbench/fAddUnitTb.sv

/* run.sh */
#!/bin/sh
# build and run with Verilator, then look for the pass line in the log
rm -f sim.log && verilator --binary --timing --assert -Wno-fatal --top-module fAddUnitTb \
	-f list.f && ./obj_dir/VfAddUnitTb +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "build or simulation stopped early" >> sim.log
cat sim.log
grep -qx "TEST OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* testbench/fAddUnitTb.sv */
// fAdd unit testbench

`timescale 1ns/1ps
`default_nettype none

`include "fAdd_settings.svh"

module fAddUnitTb import fAddPkg::*; ();

	logic clock;
	logic reset;
	logic inValid;
	logic inReady;
	fAddReq inReq;
	logic outValid;
	logic outReady;
	fAddResp outResp;

	fAddResp expectQ [$]; // oldest first
	fAddResp expectNext; // goes with the op on offer
	fAddResp expectHead;
	logic expectAny;
	string testName;
	int extraFails;
	int failMark;
	int testCount;
	int failTests;
	event runDone;
	event hang;

	fAddUnit i_fAddUnit (
		.clock(clock),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inReq(inReq),
		.outValid(outValid),
		.outReady(outReady),
		.outResp(outResp)
	);

	bind fAddUnit fAddUnit_asserts i_asserts (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// reference queue follows both handshakes
	always @(posedge clock) begin
		if (reset) begin
			expectQ.delete();
		end else begin
			if (outValid && outReady && expectQ.size() > 0)
				void'(expectQ.pop_front());
			if (inValid && inReady)
				expectQ.push_back(expectNext);
		end
		expectAny <= expectQ.size() > 0;
		expectHead <= (expectQ.size() > 0) ? expectQ[0] : '0;
	end

	function automatic floatWord toFloat(input int value);
		logic [63:0] dbl;
		floatWord word;
		dbl = $realtobits($itor(value));
		word.bits = '0;
		if (value != 0) begin
			word.field.sign = dbl[63];
			word.field.exponent = 8'(dbl[62:52] - 11'd896); // bias 1023 down to 127
			word.field.fraction = dbl[51:29]; // exact for small integers
		end
		return word;
	endfunction

	task automatic step();
		@(posedge clock);
		#2;
	endtask

	task automatic reportHang(input string what);
		$display("%s: gave up waiting, %s", testName, what);
		failTests++;
		-> hang;
		@(posedge clock);
	endtask

	task automatic loadOp(input opKind op, input floatWord a, input floatWord b,
			input floatWord want);
		inReq.op = op;
		inReq.operandA = a;
		inReq.operandB = b;
		inReq.tag = opTag'($urandom);
		expectNext.result = want;
		expectNext.tag = inReq.tag;
	endtask

	// keep the loaded op on offer until it is taken
	task automatic offer(input int limit);
		int waited;
		logic taken;
		waited = 0;
		taken = 1'b0;
		inValid = 1'b1;
		while (!taken && waited < limit) begin
			#1;
			taken = inReady;
			step();
			waited++;
		end
		inValid = 1'b0;
		if (!taken)
			reportHang("op not accepted");
	endtask

	task automatic sendOp(input opKind op, input floatWord a, input floatWord b,
			input floatWord want);
		loadOp(op, a, b, want);
		offer(20);
	endtask

	task automatic drain(input int limit);
		int waited;
		waited = 0;
		while (expectQ.size() > 0 && waited < limit) begin
			step();
			waited++;
		end
		if (expectQ.size() > 0)
			reportHang("results still missing");
	endtask

	task automatic startTest(input string name);
		testName = name;
		failMark = i_fAddUnit.i_asserts.failCount + extraFails;
	endtask

	task automatic closeTest();
		int fails;
		fails = i_fAddUnit.i_asserts.failCount + extraFails - failMark;
		testCount++;
		if (fails == 0) begin
			$display("pass %s", testName);
		end else begin
			$display("Fail %s: %0d failed checks", testName, fails);
			failTests++;
		end
	endtask

	// random integer sums and differences at one offer per cycle
	task automatic intStreamTest();
		int a;
		int b;
		opKind op;
		startTest("integer stream");
		for (int i = 0; i < 40; i++) begin
			a = int'($urandom % 32'h0010_0000);
			b = int'($urandom % 32'h0010_0000);
			if ($urandom % 2 == 1)
				a = -a;
			if ($urandom % 2 == 1)
				b = -b;
			op = ($urandom % 2 == 1) ? opSub : opAdd;
			loadOp(op, toFloat(a), toFloat(b), toFloat(op == opSub ? a - b : a + b));
			offer(1); // a bubble here means lost throughput
		end
		drain(8);
		closeTest();
	endtask

	task automatic specialTest();
		startTest("special values");
		sendOp(opSub, toFloat(12345), toFloat(12345), 32'h0000_0000);
		sendOp(opAdd, 32'h0000_1234, toFloat(77), toFloat(77)); // subnormal A
		sendOp(opSub, toFloat(-5), 32'h8000_0001, toFloat(-5));
		sendOp(opSub, 32'h0080_0000, 32'h0080_0001, 32'h8000_0000); // underflow
		sendOp(opAdd, 32'h7fc1_2345, toFloat(3), 32'h7fc0_0000);
		sendOp(opSub, 32'h7f80_0000, 32'h7f80_0000, 32'h7fc0_0000);
		sendOp(opAdd, 32'hff80_0000, toFloat(9), 32'hff80_0000);
		sendOp(opAdd, 32'h7f7f_ffff, 32'h7f7f_ffff, 32'h7f80_0000); // overflow
		drain(12);
		closeTest();
	endtask

	// queue fills and the stall walks back to the input
	task automatic backpressureTest();
		int accepted;
		int waited;
		logic taken;
		startTest("back-pressure");
		outReady = 1'b0;
		accepted = 0;
		waited = 0;
		taken = 1'b1;
		loadOp(opAdd, toFloat(0), toFloat(500), toFloat(500));
		inValid = 1'b1;
		while (taken && waited < 20) begin
			#1;
			taken = inReady;
			step();
			waited++;
			if (taken) begin
				accepted++;
				loadOp(opSub, toFloat(accepted), toFloat(500), toFloat(accepted - 500));
			end
		end
		if (taken)
			reportHang("inReady never fell");
		repeat (6) step(); // stalled output must hold
		assert (accepted <= `FADD_QUEUE_DEPTH + 3)
		else begin
			$display("Fail %s expected at most %0d actual %0d", testName,
				`FADD_QUEUE_DEPTH + 3, accepted);
			extraFails++;
		end
		outReady = 1'b1;
		offer(20); // the op left waiting goes in now
		drain(20);
		closeTest();
	endtask

	initial begin
		void'($urandom(32'h1cb4_8ada));
		reset = 1'b1;
		inValid = 1'b0;
		inReq = '0;
		outReady = 1'b1;
		expectNext = '0;
		extraFails = 0;
		failMark = 0;
		testCount = 0;
		failTests = 0;
		testName = "reset";
		repeat (10) step();
		reset = 1'b0;
		intStreamTest();
		specialTest();
		backpressureTest();
		-> runDone;
	end

	initial begin
		fork
			@runDone;
			@hang;
		join_any
		$display("%0d tests, %0d failed, %0d failed checks", testCount, failTests,
			i_fAddUnit.i_asserts.failCount + extraFails);
		if (failTests == 0 && i_fAddUnit.i_asserts.failCount + extraFails == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/fAddUnit_asserts.sv */
// fAdd unit assertions

`timescale 1ns/1ps
`default_nettype none

module fAddUnit_asserts import fAddPkg::*; (
	input logic clock,
	input logic reset,
	input logic inValid,
	input logic inReady,
	input logic outValid,
	input logic outReady,
	input fAddResp outResp,
	input logic alignValid,
	input logic sumValid,
	input logic packValid
);

	int failCount = 0;

	// every result leaves in order and keeps its tag
	resultMatch: assert property (@(posedge clock) disable iff (reset)
		outValid && outReady |-> fAddUnitTb.expectAny && outResp == fAddUnitTb.expectHead)
	else begin
		$error("Fail %0s expected %h actual %h", fAddUnitTb.testName,
			$sampled(fAddUnitTb.expectHead), $sampled(outResp));
		failCount++;
	end

	stallHold: assert property (@(posedge clock) disable iff (reset)
		outValid && !outReady |=> outValid && $stable(outResp))
	else begin
		$error("a stalled result changed or was dropped");
		failCount++;
	end

	// from an idle pipe the result crosses three stages and the queue
	emptyLatency: assert property (@(posedge clock) disable iff (reset)
		inValid && inReady && !alignValid && !sumValid && !packValid && !outValid
		|=> !outValid ##1 !outValid ##1 !outValid ##1 outValid)
	else begin
		$error("result did not appear 4 cycles after an idle handshake");
		failCount++;
	end

	resetState: assert property (@(posedge clock) reset |=> !outValid && inReady)
	else begin
		$error("outValid or inReady wrong during reset");
		failCount++;
	end

endmodule

`default_nettype wire

/* rtl/fAddUnit.sv */
// fAdd execution unit

`timescale 1ns/1ps
`default_nettype none

`include "fAdd_settings.svh"

module fAddUnit import fAddPkg::*; (
	input logic clock,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input fAddReq inReq,
	output logic outValid,
	input logic outReady,
	output fAddResp outResp
);

	localparam int queueAddrWidth = $clog2(`FADD_QUEUE_DEPTH);

	logic alignValid;
	logic alignReady;
	alignedOps alignOut;
	logic sumValid;
	logic sumReady;
	sumNorm sumOut;
	logic packValid;
	fAddResp packOut;

	logic writeEn;
	logic readEn;
	logic [queueAddrWidth-1:0] writeAddr;
	logic [queueAddrWidth-1:0] readAddr;
	logic full;
	logic empty;

	fAddResp queueMem [`FADD_QUEUE_DEPTH];

	fAddAlign i_fAddAlign (
		.clock(clock),
		.reset(reset),
		.inValid(inValid),
		.inReady(inReady),
		.inReq(inReq),
		.outValid(alignValid),
		.outReady(alignReady),
		.outOps(alignOut)
	);

	fAddSum i_fAddSum (
		.clock(clock),
		.reset(reset),
		.inValid(alignValid),
		.inReady(alignReady),
		.inOps(alignOut),
		.outValid(sumValid),
		.outReady(sumReady),
		.outNorm(sumOut)
	);

	// pack holds its item while the queue is full
	fAddPack i_fAddPack (
		.clock(clock),
		.reset(reset),
		.inValid(sumValid),
		.inReady(sumReady),
		.inNorm(sumOut),
		.outValid(packValid),
		.outReady(!full),
		.outResp(packOut)
	);

	assign writeEn = packValid && !full;
	assign readEn = outValid && outReady;

	ringBuffCtrl #(
		.numEntry(`FADD_QUEUE_DEPTH)
	) i_ringBuffCtrl (
		.clock(clock),
		.reset(reset),
		.writeEn(writeEn),
		.readEn(readEn),
		.writeAddr(writeAddr),
		.readAddr(readAddr),
		.full(full),
		.empty(empty)
	);

	always_ff @(posedge clock) begin
		if (writeEn) begin
			queueMem[writeAddr] <= packOut;
		end
	end

	assign outValid = !empty; // head offered whenever present
	assign outResp = queueMem[readAddr];

endmodule

`default_nettype wire

/* rtl/ringBuffCtrl.sv */
// ring buffer control

`timescale 1ns/1ps
`default_nettype none

module ringBuffCtrl #(
	parameter int numEntry = 4
) (
	input logic clock,
	input logic reset,
	input logic writeEn,
	input logic readEn,
	output logic [$clog2(numEntry)-1:0] writeAddr,
	output logic [$clog2(numEntry)-1:0] readAddr,
	output logic full,
	output logic empty
);

	localparam int countWidth = $clog2(numEntry + 1);

	logic [countWidth-1:0] count;

	assign full = count == countWidth'(numEntry);
	assign empty = count == '0;

	always_ff @(posedge clock) begin
		if (reset) begin
			writeAddr <= '0;
			readAddr <= '0;
			count <= '0;
		end else begin
			if (writeEn)
				writeAddr <= (writeAddr == numEntry - 1) ? '0 : writeAddr + 1'b1;
			if (readEn)
				readAddr <= (readAddr == numEntry - 1) ? '0 : readAddr + 1'b1;
			// simultaneous read and write leave the level alone
			if (writeEn && !readEn)
				count <= count + 1'b1;
			else if (readEn && !writeEn)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* rtl/fAddPack.sv */
// fAdd pack stage

`timescale 1ns/1ps
`default_nettype none

module fAddPack import fAddPkg::*; (
	input logic clock,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input sumNorm inNorm,
	output logic outValid,
	input logic outReady,
	output fAddResp outResp
);

	floatWord word;
	fAddResp packNext;

	assign inReady = !outValid || outReady;

	always_comb begin
		if (inNorm.special) begin
			word = inNorm.specialWord; // NaN and infinity already final
		end else if (inNorm.zero || inNorm.exponent <= 0) begin
			word.bits = {inNorm.sign, 31'd0}; // underflow flushes to signed zero
		end else if (inNorm.exponent >= 255) begin
			word.bits = {inNorm.sign, 8'hff, 23'd0};
		end else begin
			word.field.sign = inNorm.sign;
			word.field.exponent = inNorm.exponent[7:0];
			word.field.fraction = inNorm.significand[22:0]; // truncate, toward zero
		end
		packNext.result = word;
		packNext.tag = inNorm.tag;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clock) begin
		if (inValid && inReady) begin
			outResp <= packNext;
		end
	end

endmodule

`default_nettype wire

/* rtl/fAddSum.sv */
// fAdd sum and normalize stage

`timescale 1ns/1ps
`default_nettype none

module fAddSum import fAddPkg::*; (
	input logic clock,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input alignedOps inOps,
	output logic outValid,
	input logic outReady,
	output sumNorm outNorm
);

	logic [27:0] total;
	logic [26:0] body;
	logic [4:0] lead;
	logic [26:0] shiftedBody;
	logic signed [9:0] expBase;
	logic isZero;
	sumNorm sumNext;

	assign inReady = !outValid || outReady;

	always_comb begin
		// large is never below small, so the difference stays positive
		if (inOps.effSub)
			total = {1'b0, inOps.largeSig} - {1'b0, inOps.smallSig};
		else
			total = {1'b0, inOps.largeSig} + {1'b0, inOps.smallSig};
		body = total[26:0];
		isZero = total == '0;

		// priority count, highest set bit wins
		lead = 5'd27;
		for (int i = 0; i < 27; i++) begin
			if (body[i])
				lead = 5'(26 - i);
		end
		shiftedBody = body << lead;
		expBase = $signed({2'b00, inOps.largeExp});

		sumNext.special = inOps.special;
		sumNext.specialWord = inOps.specialWord;
		sumNext.sign = (isZero && inOps.effSub) ? 1'b0 : inOps.sign; // x - x is +0
		if (total[27]) begin // carry out, one place right
			sumNext.exponent = expBase + 10'sd1;
			sumNext.significand = total[27:4];
		end else begin
			sumNext.exponent = expBase - $signed({5'd0, lead});
			sumNext.significand = shiftedBody[26:3];
		end
		sumNext.zero = isZero;
		sumNext.tag = inOps.tag;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clock) begin
		if (inValid && inReady) begin
			outNorm <= sumNext;
		end
	end

endmodule

`default_nettype wire

/* rtl/fAddAlign.sv */
// fAdd align stage

`timescale 1ns/1ps
`default_nettype none

module fAddAlign import fAddPkg::*; (
	input logic clock,
	input logic reset,
	input logic inValid,
	output logic inReady,
	input fAddReq inReq,
	output logic outValid,
	input logic outReady,
	output alignedOps outOps
);

	floatWord opA;
	floatWord opB;
	logic signA;
	logic signB;
	logic zeroA;
	logic zeroB;
	logic infA;
	logic infB;
	logic nanA;
	logic nanB;
	logic [30:0] magA;
	logic [30:0] magB;
	logic swap;
	logic [7:0] expLarge;
	logic [7:0] expSmall;
	logic [7:0] expDiff;
	logic [26:0] sigA;
	logic [26:0] sigB;
	logic [26:0] sigSmall;
	logic [26:0] stickyMask;
	logic [26:0] smallShifted;
	alignedOps alignNext;

	assign inReady = !outValid || outReady;

	always_comb begin
		opA = inReq.operandA;
		opB = inReq.operandB;
		signA = opA.field.sign;
		signB = opB.field.sign ^ (inReq.op == opSub); // subtract flips B
		zeroA = opA.field.exponent == 8'd0; // subnormal counts as zero
		zeroB = opB.field.exponent == 8'd0;
		infA = (opA.field.exponent == 8'hff) && (opA.field.fraction == '0);
		infB = (opB.field.exponent == 8'hff) && (opB.field.fraction == '0);
		nanA = (opA.field.exponent == 8'hff) && (opA.field.fraction != '0);
		nanB = (opB.field.exponent == 8'hff) && (opB.field.fraction != '0);
		magA = zeroA ? '0 : opA.bits[30:0];
		magB = zeroB ? '0 : opB.bits[30:0];
		sigA = zeroA ? '0 : {1'b1, opA.field.fraction, 3'b000};
		sigB = zeroB ? '0 : {1'b1, opB.field.fraction, 3'b000};

		// order by magnitude, A wins ties
		swap = magB > magA;
		expLarge = swap ? opB.field.exponent : opA.field.exponent;
		expSmall = swap ? opA.field.exponent : opB.field.exponent;
		expDiff = expLarge - expSmall;
		sigSmall = swap ? sigA : sigB;

		// bits shifted out collapse into bit 0
		stickyMask = (27'd1 << expDiff) - 27'd1;
		smallShifted = sigSmall >> expDiff;
		smallShifted[0] = smallShifted[0] | (|(sigSmall & stickyMask));

		alignNext.special = nanA || nanB || infA || infB;
		if (nanA || nanB || (infA && infB && (signA != signB)))
			alignNext.specialWord.bits = 32'h7fc0_0000; // canonical quiet NaN
		else if (infA)
			alignNext.specialWord.bits = {signA, 8'hff, 23'd0};
		else
			alignNext.specialWord.bits = {signB, 8'hff, 23'd0};
		alignNext.sign = swap ? signB : signA;
		alignNext.largeExp = expLarge;
		alignNext.largeSig = swap ? sigB : sigA;
		alignNext.smallSig = smallShifted;
		alignNext.effSub = signA ^ signB;
		alignNext.tag = inReq.tag;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clock) begin
		if (inValid && inReady) begin
			outOps <= alignNext;
		end
	end

endmodule

`default_nettype wire

/* rtl/fAddPkg.sv */
// fAdd shared types

`default_nettype none

`include "fAdd_settings.svh"

package fAddPkg;

	// single precision word, raw or split into fields
	typedef union packed {
		logic [31:0] bits;
		struct packed {
			logic sign;
			logic [7:0] exponent;
			logic [22:0] fraction;
		} field;
	} floatWord;

	typedef enum logic {
		opAdd = 1'b0,
		opSub = 1'b1
	} opKind;

	typedef struct packed {
		logic [`FADD_INDEX_WIDTH-1:0] index;
		logic [`FADD_ISSUE_WIDTH-1:0] issueNo;
	} opTag;

	typedef struct packed {
		opKind op;
		floatWord operandA;
		floatWord operandB;
		opTag tag;
	} fAddReq;

	// after alignment, significands carry 3 guard bits
	typedef struct packed {
		logic special;
		floatWord specialWord;
		logic sign;
		logic [7:0] largeExp;
		logic [26:0] largeSig;
		logic [26:0] smallSig;
		logic effSub;
		opTag tag;
	} alignedOps;

	typedef struct packed {
		logic special;
		floatWord specialWord;
		logic sign;
		logic signed [9:0] exponent; // may leave the 1..254 range
		logic [23:0] significand;
		logic zero;
		opTag tag;
	} sumNorm;

	typedef struct packed {
		floatWord result;
		opTag tag;
	} fAddResp;

endpackage

`default_nettype wire

/* rtl/fAdd_settings.svh */
// fAdd unit settings

`ifndef FADD_SETTINGS_SVH
`define FADD_SETTINGS_SVH

// result queue entries
`define FADD_QUEUE_DEPTH 4

// destination register index
`define FADD_INDEX_WIDTH 6

// issue number carried with each op
`define FADD_ISSUE_WIDTH 8

`endif
